//--- include/bpModel.svh
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// reference state as the DUT holds it after each edge
bpPkg::BtbEntry            mdlBtb [bpPkg::NUM_ENTRIES];
logic [1:0]                mdlCtr [bpPkg::NUM_CTRS];
logic [bpPkg::ID_BITS-1:0] mdlSpec;
logic [bpPkg::ID_BITS-1:0] mdlCom;

task automatic resetModel();
    foreach (mdlBtb[i]) mdlBtb[i] = '0;
    foreach (mdlCtr[i]) mdlCtr[i] = bpPkg::CTR_INIT;
    mdlSpec = '0;
    mdlCom  = '0;
endtask

// hit test against the current table with the slot returned in e
function automatic logic lookupTarget(input logic [bpPkg::HADDR_BITS-1:0] pc,
                                      output bpPkg::BtbEntry e);
    e = mdlBtb[pc[bpPkg::TAG_LO-1:bpPkg::BLOCK_BITS]];
    return e.valid && (e.tag == pc[bpPkg::HADDR_BITS-1:bpPkg::TAG_LO])
        && (e.src >= pc[bpPkg::BLOCK_BITS-1:0]);
endfunction

task automatic installTarget(input bpPkg::BTUpdate u);
    bpPkg::BtbEntry old;
    bpPkg::BtbEntry nw;
    old = mdlBtb[u.src[bpPkg::TAG_LO-1:bpPkg::BLOCK_BITS]];
    nw  = {1'b1, u.src[bpPkg::HADDR_BITS-1:bpPkg::TAG_LO], u.src[bpPkg::BLOCK_BITS-1:0],
           u.dst, u.isJump, u.compr, 1'b0};
    if (old.valid && old.tag == nw.tag) begin
        if (old.src == nw.src) nw.multiple = old.multiple;
        else if (old.src < nw.src) nw = {old[$bits(old)-1:1], 1'b1};
        else nw.multiple = 1'b1;
    end
    mdlBtb[u.src[bpPkg::TAG_LO-1:bpPkg::BLOCK_BITS]] = nw;
endtask

task automatic trainCounter(input logic [bpPkg::ID_BITS-1:0] idx, input logic tk);
    if (tk && mdlCtr[idx] != 2'b11) mdlCtr[idx] = mdlCtr[idx] + 2'd1;
    else if (!tk && mdlCtr[idx] != 2'b00) mdlCtr[idx] = mdlCtr[idx] - 2'd1;
endtask

`endif

//--- bench/branchPredictorTb.sv
`timescale 1ns/1ps
`default_nettype none

module branchPredictorTb;

    logic                       clk;
    logic                       rst;
    bpPkg::BranchProv           branchProv;
    logic                       pcValid;
    logic [31:0]                pc;
    logic                       branchTaken;
    logic                       isJump;
    logic [31:0]                branchSrc;
    logic [31:0]                branchDst;
    logic [bpPkg::ID_BITS-1:0]  branchId;
    logic                       multipleBranches;
    logic                       branchFound;
    logic                       branchCompr;
    bpPkg::BTUpdate             btUpdates [bpPkg::NUM_IN];
    bpPkg::CommitUOp            comUOp;
    logic [bpPkg::ID_BITS-1:0]  comHistory;
    logic                       branchCommitted;

    // expected outputs for the current cycle
    logic                         expFound;
    logic                         expJump;
    logic                         expCompr;
    logic                         expMulti;
    logic                         expTaken;
    logic                         expCommitted;
    logic [bpPkg::HADDR_BITS-1:0] expSrcHalf;
    logic [bpPkg::HADDR_BITS-1:0] expDst;

    logic [31:0] lfsrState;
    int          cyc;
    int          hits;
    int          multiHits;
    int          satHigh;
    int          satLow;
    int          dualUpdates;
    int          recoveries;

    `include "bpModel.svh"

    branchPredictor dut_i (
        .clk              (clk),
        .rst              (rst),
        .branchProv       (branchProv),
        .pcValid          (pcValid),
        .pc               (pc),
        .branchTaken      (branchTaken),
        .isJump           (isJump),
        .branchSrc        (branchSrc),
        .branchDst        (branchDst),
        .branchId         (branchId),
        .multipleBranches (multipleBranches),
        .branchFound      (branchFound),
        .branchCompr      (branchCompr),
        .btUpdates        (btUpdates),
        .comUOp           (comUOp),
        .comHistory       (comHistory),
        .branchCommitted  (branchCommitted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32,22,2,1
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = nextLfsr(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    // two tags over four sets keep conflicts and shared blocks coming back
    function automatic logic [bpPkg::HADDR_BITS-1:0] poolAddr();
        logic [bpPkg::TAG_BITS-1:0]   tag;
        logic [31:0]                  idx;
        logic [31:0]                  offs;
        logic [bpPkg::HADDR_BITS-1:0] a;
        tag = 'h1;
        if (takeBits(1) != 0) tag = 'hA3;
        idx = takeBits(2);
        offs = takeBits(bpPkg::BLOCK_BITS);
        a = '0;
        a[bpPkg::HADDR_BITS-1:bpPkg::TAG_LO] = tag;
        a[bpPkg::TAG_LO-1:bpPkg::BLOCK_BITS] = idx[bpPkg::BTB_IDX_BITS-1:0];
        a[bpPkg::BLOCK_BITS-1:0] = offs[bpPkg::BLOCK_BITS-1:0];
        return a;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
                              $time, name, got, exp));
        end
    endtask

    // apply the inputs that were held across the last edge
    task automatic stepModel();
        bpPkg::BtbEntry            e;
        bpPkg::BTUpdate            winner;
        logic [bpPkg::ID_BITS-1:0] idx;
        int                        nValid;
        if (branchProv.taken) begin
            recoveries++;
            if (branchProv.predicted) begin
                mdlSpec = {branchProv.branchID[bpPkg::ID_BITS-2:0], branchProv.branchTaken};
            end else begin
                mdlSpec = branchProv.branchID;
            end
        end else if (expFound && !expJump) begin
            mdlSpec = {mdlSpec[bpPkg::ID_BITS-2:0], expTaken};
        end
        expCommitted = comUOp.valid && comUOp.isBranch;
        if (expCommitted) mdlCom = {mdlCom[bpPkg::ID_BITS-2:0], comUOp.branchTaken};

        // lookup sees the table before this edge's install
        if (pcValid) begin
            expFound   = lookupTarget(pc[31:1], e);
            expSrcHalf = {pc[31:bpPkg::BLOCK_BITS+1], e.src};
            expDst     = e.dst;
            expJump    = e.isJump;
            expCompr   = e.compr;
            expMulti   = e.multiple;
        end else begin
            expFound = 1'b0;
        end
        if (expFound) hits++;
        if (expFound && expMulti) multiHits++;

        winner = '0;
        nValid = 0;
        for (int i = 0; i < bpPkg::NUM_IN; i++) begin
            if (btUpdates[i].valid) begin
                winner = btUpdates[i];
                nValid++;
            end
        end
        if (nValid > 1) dualUpdates++;
        if (winner.valid) installTarget(winner);

        if (expCommitted && comUOp.predicted) begin
            idx = comUOp.pc[bpPkg::ID_BITS-1:0] ^ comUOp.branchID;
            if (comUOp.branchTaken && mdlCtr[idx] == 2'b11) satHigh++;
            if (!comUOp.branchTaken && mdlCtr[idx] == 2'b00) satLow++;
            trainCounter(idx, comUOp.branchTaken);
        end
        expTaken = mdlCtr[expSrcHalf[bpPkg::ID_BITS-1:0] ^ mdlSpec][1];
    endtask

    task automatic compareOutputs();
        checkValue("branchFound", branchFound, expFound);
        checkValue("branchCommitted", branchCommitted, expCommitted);
        checkValue("branchId", branchId, mdlSpec);
        checkValue("comHistory", comHistory, mdlCom);
        if (expFound) begin // the rest is only defined on a hit
            checkValue("branchSrc", branchSrc, {expSrcHalf, 1'b0});
            checkValue("branchDst", branchDst, {expDst, 1'b0});
            checkValue("isJump", isJump, expJump);
            checkValue("branchCompr", branchCompr, expCompr);
            checkValue("multipleBranches", multipleBranches, expMulti);
            checkValue("branchTaken", branchTaken, expTaken);
        end
    endtask

    task automatic driveInputs();
        logic [31:0] r;
        pcValid = (takeBits(2) != 0);
        pc = {poolAddr(), 1'b0};
        for (int i = 0; i < bpPkg::NUM_IN; i++) begin
            btUpdates[i].valid = (takeBits(2) == 0);
            btUpdates[i].src = poolAddr();
            r = takeBits(31);
            btUpdates[i].dst = r[30:0];
            btUpdates[i].isJump = (takeBits(2) == 0);
            btUpdates[i].compr = (takeBits(1) != 0);
        end
        comUOp.valid = (takeBits(1) != 0);
        comUOp.isBranch = (takeBits(2) != 0);
        comUOp.predicted = (takeBits(3) != 0);
        comUOp.branchTaken = (takeBits(1) != 0);
        comUOp.branchID = (takeBits(1) != 0) ? mdlSpec : '0; // zero keeps indices repeating
        comUOp.pc = poolAddr();
        branchProv.taken = (takeBits(4) == 0);
        branchProv.predicted = (takeBits(1) != 0);
        r = takeBits(bpPkg::ID_BITS);
        branchProv.branchID = r[bpPkg::ID_BITS-1:0];
        branchProv.branchTaken = (takeBits(1) != 0);
    endtask

    function automatic logic coverageMet();
        return cyc >= 2000 && hits >= 50 && multiHits >= 10 && satHigh >= 5
            && satLow >= 5 && dualUpdates >= 5 && recoveries >= 5;
    endfunction

    initial begin
        rst = 1'b1;
        pcValid = 1'b0;
        pc = '0;
        comUOp = '0;
        branchProv = '0;
        foreach (btUpdates[i]) btUpdates[i] = '0;
        lfsrState = 32'd69504;
        cyc = 0;
        hits = 0;
        multiHits = 0;
        satHigh = 0;
        satLow = 0;
        dualUpdates = 0;
        recoveries = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        resetModel();
        expFound = 1'b0;
        expJump = 1'b0;
        expCompr = 1'b0;
        expMulti = 1'b0;
        expTaken = 1'b0;
        expCommitted = 1'b0;
        expSrcHalf = '0;
        expDst = '0;

        // random run until every behavior has shown up or 20000 cycles pass
        while (!coverageMet() && cyc < 20000) begin
            @(posedge clk);
            #1;
            stepModel();
            compareOutputs();
            driveInputs();
            cyc++;
        end

        if (coverageMet()) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            failRun($sformatf("timed out after %0d cycles before all cases were exercised", cyc));
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
logic/bpPkg.sv
logic/branchTargetBuffer.sv
logic/patternHistoryTable.sv
logic/globalHistory.sv
logic/branchPredictor.sv
bench/branchPredictorTb.sv

//--- logic/bpPkg.sv
`default_nettype none

package bpPkg;

    localparam int NUM_IN = 2;
    localparam int NUM_ENTRIES = 32;
    localparam int ID_BITS = 12;
    localparam int BTB_IDX_BITS = $clog2(NUM_ENTRIES);
    localparam int BLOCK_BITS = 2; // halfwords per fetch block, log2
    localparam int HADDR_BITS = 31; // pc without bit 0
    localparam int TAG_LO = BLOCK_BITS + BTB_IDX_BITS;
    localparam int TAG_BITS = HADDR_BITS - TAG_LO;
    localparam int NUM_CTRS = 2 ** ID_BITS;
    localparam logic [1:0] CTR_INIT = 2'b01; // weakly not-taken

    // mispredict recovery from the branch unit
    typedef struct packed {
        logic taken;
        logic predicted;
        logic [ID_BITS-1:0] branchID;
        logic branchTaken;
    } BranchProv;

    typedef struct packed {
        logic valid;
        logic [HADDR_BITS-1:0] src;
        logic [HADDR_BITS-1:0] dst;
        logic isJump;
        logic compr;
    } BTUpdate;

    typedef struct packed {
        logic valid;
        logic isBranch;
        logic predicted;
        logic branchTaken;
        logic [ID_BITS-1:0] branchID; // history seen at prediction
        logic [HADDR_BITS-1:0] pc;
    } CommitUOp;

    // one slot of the target buffer
    typedef struct packed {
        logic valid;
        logic [TAG_BITS-1:0] tag;
        logic [BLOCK_BITS-1:0] src; // offset inside the block
        logic [HADDR_BITS-1:0] dst;
        logic isJump;
        logic compr;
        logic multiple; // another branch shares this block
    } BtbEntry;

endpackage

`default_nettype wire

//--- logic/branchPredictor.sv
`timescale 1ns/1ps
`default_nettype none

module branchPredictor (
    input  logic                       clk,
    input  logic                       rst,
    input  bpPkg::BranchProv           branchProv,

    // fetch
    input  logic                       pcValid,
    input  logic [31:0]                pc,
    output logic                       branchTaken,
    output logic                       isJump,
    output logic [31:0]                branchSrc,
    output logic [31:0]                branchDst,
    output logic [bpPkg::ID_BITS-1:0]  branchId,
    output logic                       multipleBranches,
    output logic                       branchFound,
    output logic                       branchCompr,

    // branch execution units
    input  bpPkg::BTUpdate             btUpdates [bpPkg::NUM_IN],

    // commit
    input  bpPkg::CommitUOp            comUOp,
    output logic [bpPkg::ID_BITS-1:0]  comHistory,
    output logic                       branchCommitted
);

    bpPkg::BTUpdate btUpdate;

    logic [bpPkg::HADDR_BITS-1:0] srcHalf;
    logic [bpPkg::HADDR_BITS-1:0] dstHalf;
    logic [bpPkg::ID_BITS-1:0]    specHistory;
    logic [bpPkg::ID_BITS-1:0]    readIdx;
    logic [bpPkg::ID_BITS-1:0]    writeIdx;
    logic                         commitBranch;
    logic                         trainEn;

    // highest valid port wins, the rest are dropped
    always_comb begin
        btUpdate = '0;
        for (int i = 0; i < bpPkg::NUM_IN; i++) begin
            if (btUpdates[i].valid) begin
                btUpdate = btUpdates[i];
            end
        end
    end

    branchTargetBuffer btb_i (
        .clk              (clk),
        .rst              (rst),
        .pcValid          (pcValid),
        .pc               (pc[31:1]),
        .btUpdate         (btUpdate),
        .branchFound      (branchFound),
        .branchSrc        (srcHalf),
        .branchDst        (dstHalf),
        .branchIsJump     (isJump),
        .branchCompr      (branchCompr),
        .multipleBranches (multipleBranches)
    );

    assign branchSrc = {srcHalf, 1'b0};
    assign branchDst = {dstHalf, 1'b0};

    // gshare: halfword address bits xor history, same rule on both sides
    assign readIdx  = srcHalf[bpPkg::ID_BITS-1:0] ^ specHistory;
    assign writeIdx = comUOp.pc[bpPkg::ID_BITS-1:0] ^ comUOp.branchID;

    assign commitBranch = comUOp.valid && comUOp.isBranch;
    assign trainEn      = commitBranch && comUOp.predicted; // unpredicted ones never read a ctr

    patternHistoryTable pht_i (
        .clk        (clk),
        .rst        (rst),
        .readAddr   (readIdx),
        .writeEn    (trainEn),
        .writeAddr  (writeIdx),
        .writeTaken (comUOp.branchTaken),
        .taken      (branchTaken)
    );

    globalHistory ghr_i (
        .clk         (clk),
        .rst         (rst),
        .specShift   (branchFound && !isJump),
        .specTaken   (branchTaken),
        .branchProv  (branchProv),
        .commitShift (commitBranch),
        .commitTaken (comUOp.branchTaken),
        .specHistory (specHistory),
        .comHistory  (comHistory)
    );

    assign branchId = specHistory; // history used for this prediction

    // perf counter strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            branchCommitted <= 1'b0;
        end else begin
            branchCommitted <= commitBranch;
        end
    end

endmodule

`default_nettype wire

//--- logic/branchTargetBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module branchTargetBuffer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pcValid,
    input  logic [bpPkg::HADDR_BITS-1:0]  pc,
    input  bpPkg::BTUpdate                btUpdate,
    output logic                          branchFound,
    output logic [bpPkg::HADDR_BITS-1:0]  branchSrc,
    output logic [bpPkg::HADDR_BITS-1:0]  branchDst,
    output logic                          branchIsJump,
    output logic                          branchCompr,
    output logic                          multipleBranches
);

    bpPkg::BtbEntry entries [bpPkg::NUM_ENTRIES];

    logic [bpPkg::BTB_IDX_BITS-1:0] rdIdx;
    logic [bpPkg::TAG_BITS-1:0]     rdTag;
    logic [bpPkg::BLOCK_BITS-1:0]   rdOffs;
    bpPkg::BtbEntry                 rdEntry;
    logic                           hit;

    logic [bpPkg::BTB_IDX_BITS-1:0] wrIdx;
    logic [bpPkg::TAG_BITS-1:0]     wrTag;
    logic [bpPkg::BLOCK_BITS-1:0]   wrOffs;
    bpPkg::BtbEntry                 wrOld;
    bpPkg::BtbEntry                 wrNew;

    // lookup side
    assign rdIdx   = pc[bpPkg::TAG_LO-1:bpPkg::BLOCK_BITS];
    assign rdTag   = pc[bpPkg::HADDR_BITS-1:bpPkg::TAG_LO];
    assign rdOffs  = pc[bpPkg::BLOCK_BITS-1:0];
    assign rdEntry = entries[rdIdx];

    // a branch before the fetch offset is already behind us
    assign hit = rdEntry.valid && (rdEntry.tag == rdTag) && (rdEntry.src >= rdOffs);

    always_ff @(posedge clk) begin
        if (rst) begin
            branchFound <= 1'b0;
        end else begin
            branchFound <= pcValid && hit;
        end
    end

    always_ff @(posedge clk) begin
        if (pcValid) begin
            branchSrc        <= {pc[bpPkg::HADDR_BITS-1:bpPkg::BLOCK_BITS], rdEntry.src};
            branchDst        <= rdEntry.dst;
            branchIsJump     <= rdEntry.isJump;
            branchCompr      <= rdEntry.compr;
            multipleBranches <= rdEntry.multiple;
        end
    end

    // install side
    assign wrIdx  = btUpdate.src[bpPkg::TAG_LO-1:bpPkg::BLOCK_BITS];
    assign wrTag  = btUpdate.src[bpPkg::HADDR_BITS-1:bpPkg::TAG_LO];
    assign wrOffs = btUpdate.src[bpPkg::BLOCK_BITS-1:0];
    assign wrOld  = entries[wrIdx];

    always_comb begin
        wrNew.valid    = 1'b1;
        wrNew.tag      = wrTag;
        wrNew.src      = wrOffs;
        wrNew.dst      = btUpdate.dst;
        wrNew.isJump   = btUpdate.isJump;
        wrNew.compr    = btUpdate.compr;
        wrNew.multiple = 1'b0; // fresh block

        if (wrOld.valid && (wrOld.tag == wrTag)) begin
            if (wrOld.src == wrOffs) begin
                wrNew.multiple = wrOld.multiple; // same branch, refresh target
            end else if (wrOld.src < wrOffs) begin
                // earlier branch stays, it is hit first
                wrNew          = wrOld;
                wrNew.multiple = 1'b1;
            end else begin
                wrNew.multiple = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bpPkg::NUM_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (btUpdate.valid) begin
            entries[wrIdx] <= wrNew;
        end
    end

endmodule

`default_nettype wire

//--- logic/globalHistory.sv
`timescale 1ns/1ps
`default_nettype none

module globalHistory (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       specShift,
    input  logic                       specTaken,
    input  bpPkg::BranchProv           branchProv,
    input  logic                       commitShift,
    input  logic                       commitTaken,
    output logic [bpPkg::ID_BITS-1:0]  specHistory,
    output logic [bpPkg::ID_BITS-1:0]  comHistory
);

    logic [bpPkg::ID_BITS-1:0] specNext;

    // recovery wins over a lookup shift in the same cycle
    always_comb begin
        specNext = specHistory;
        if (branchProv.taken) begin
            if (branchProv.predicted) begin
                specNext = {branchProv.branchID[bpPkg::ID_BITS-2:0], branchProv.branchTaken};
            end else begin
                specNext = branchProv.branchID; // never shifted in
            end
        end else if (specShift) begin
            specNext = {specHistory[bpPkg::ID_BITS-2:0], specTaken};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            specHistory <= '0;
        end else begin
            specHistory <= specNext;
        end
    end

    // architectural history, advanced at retirement
    always_ff @(posedge clk) begin
        if (rst) begin
            comHistory <= '0;
        end else if (commitShift) begin
            comHistory <= {comHistory[bpPkg::ID_BITS-2:0], commitTaken};
        end
    end

endmodule

`default_nettype wire

//--- logic/patternHistoryTable.sv
`timescale 1ns/1ps
`default_nettype none

module patternHistoryTable (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bpPkg::ID_BITS-1:0]  readAddr,
    input  logic                       writeEn,
    input  logic [bpPkg::ID_BITS-1:0]  writeAddr,
    input  logic                       writeTaken,
    output logic                       taken
);

    logic [1:0] counters [bpPkg::NUM_CTRS];
    logic [1:0] curCtr;

    assign taken  = counters[readAddr][1]; // msb is the prediction
    assign curCtr = counters[writeAddr];

    // two-bit saturating training
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bpPkg::NUM_CTRS; i++) begin
                counters[i] <= bpPkg::CTR_INIT;
            end
        end else if (writeEn) begin
            if (writeTaken) begin
                if (curCtr != 2'b11) begin
                    counters[writeAddr] <= curCtr + 2'd1;
                end
            end else begin
                if (curCtr != 2'b00) begin
                    counters[writeAddr] <= curCtr - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire
